// ==== cpu_cfg_pkg.sv ====
/*
 * Widths, register count and reset address shared by every pipeline stage.
 * Stages import it inside the module body and use scoped names in port lists.
 */
package cpu_cfg_pkg;

    // Datapath
    localparam int XLEN = 32;                   // Data and address width
    typedef logic [XLEN-1:0] word_t;            // One data or address word

    // Register file
    localparam int NUM_REGS = 32;
    localparam int REG_AW   = $clog2(NUM_REGS); // Register number width
    typedef logic [REG_AW-1:0] reg_addr_t;

    // Fetch
    localparam word_t RESET_PC = '0;            // First fetch address after reset
    localparam word_t PC_STEP  = 32'd4;         // Byte step per instruction

endpackage

// ==== cpu_isa_pkg.sv ====
/*
 * Instruction encoding for the load/store core.
 * Field bounds, opcode bits and ALU operation codes used by decode and execute.
 */
package cpu_isa_pkg;

    typedef logic [31:0] instr_t;   // One instruction word
    typedef logic [5:0]  opcode_t;  // Top six bits of the instruction

    localparam instr_t NOP_INSTR = '0; // All zero word does nothing

    // Field bounds
    localparam int OP_MSB    = 31;
    localparam int OP_LSB    = 26;
    localparam int RS_MSB    = 25;
    localparam int RS_LSB    = 21;
    localparam int RT_MSB    = 20;
    localparam int RT_LSB    = 16;
    localparam int RD_MSB    = 15;
    localparam int RD_LSB    = 11;
    localparam int FUNCT_MSB = 5;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_MSB   = 25;
    localparam int IMM_LSB   = 0;
    localparam int IMM_W     = 26; // Load immediate width before sign extension

    // Opcode control bits
    localparam int OP_MEM_BIT = 3; // Memory access
    localparam int OP_WB_BIT  = 2; // Write back, or load when OP_MEM_BIT is set

    // Named opcodes, top bits 01 mark load immediate
    localparam opcode_t OP_ALU    = 6'b000000; // Result dropped
    localparam opcode_t OP_ALU_WB = 6'b000100;
    localparam opcode_t OP_STORE  = 6'b001000;
    localparam opcode_t OP_LOAD   = 6'b001100;
    localparam opcode_t OP_LI     = 6'b010000;

    // ALU operation, taken from funct[5:3]
    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_ADD  = 3'd0;
    localparam alu_op_t ALU_SUB  = 3'd1;
    localparam alu_op_t ALU_AND  = 3'd2;
    localparam alu_op_t ALU_OR   = 3'd3;
    localparam alu_op_t ALU_XOR  = 3'd4;
    localparam alu_op_t ALU_PASS = 3'd7; // Operand a straight through

    // EX operand source
    typedef logic [1:0] fwd_sel_t;
    localparam fwd_sel_t FWD_REG = 2'd0; // Value read in decode
    localparam fwd_sel_t FWD_WB  = 2'd1; // MEM/WB write-back data
    localparam fwd_sel_t FWD_MEM = 2'd2; // EX/MEM ALU result

endpackage

// ==== alu.sv ====
/*
 * Combinational ALU for the execute stage.
 * Add, subtract, and, or, xor, plus a pass of operand a for load immediate.
 */
`timescale 1ns/1ps

module alu (
    input  cpu_cfg_pkg::word_t   a,
    input  cpu_cfg_pkg::word_t   b,
    input  cpu_isa_pkg::alu_op_t op,
    output cpu_cfg_pkg::word_t   y
);
    import cpu_isa_pkg::*;

    always_comb
    begin
        case (op)
            ALU_ADD:  y = a + b;  // Wraps modulo 2^32
            ALU_SUB:  y = a - b;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_PASS: y = a;      // Sign-extended immediate arrives on a
            default:  y = '0;     // Unused codes
        endcase
    end

endmodule

// ==== fetch_unit.sv ====
/*
 * Instruction fetch stage. Drives the instruction address from the PC
 * and captures the returned word into IF/ID, holding both while stalled.
 */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,     // Load-use hold from hazard unit
    input  cpu_isa_pkg::instr_t i_data,    // Combinational instruction memory
    output cpu_cfg_pkg::word_t  i_addr,
    output cpu_isa_pkg::instr_t if_instr   // IF/ID instruction register
);
    import cpu_cfg_pkg::*;
    import cpu_isa_pkg::*;

    word_t pc;

    assign i_addr = pc;

    // Program counter
    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= RESET_PC;
        else if (!stall)
            pc <= pc + PC_STEP; // Plain sequential fetch, no branches
    end

    // IF/ID register
    always_ff @(posedge clk)
    begin
        if (rst)
            if_instr <= NOP_INSTR;
        else if (!stall)
            if_instr <= i_data; // Held so decode retries after the bubble
    end

    // Fetch address only steps forward or holds
    pc_step_chk: assert property (
        @(posedge clk) disable iff (rst)
        ($past(rst) == 1'b0) |-> (i_addr == $past(i_addr) + PC_STEP) ||
                                 (i_addr == $past(i_addr))
    ) else $error("i_addr moved by something other than PC_STEP");

endmodule

// ==== decode_unit.sv ====
/*
 * Decode stage. Splits the IF/ID word, drives register file reads and
 * loads the ID/EX register, or a bubble with all control cleared on stall.
 */
`timescale 1ns/1ps

module decode_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  cpu_isa_pkg::instr_t     if_instr,
    input  cpu_cfg_pkg::word_t      rs_data,   // Register file read data
    input  cpu_cfg_pkg::word_t      rt_data,
    output cpu_cfg_pkg::reg_addr_t  rs_addr,   // Combinational read addresses
    output cpu_cfg_pkg::reg_addr_t  rt_addr,
    output cpu_cfg_pkg::reg_addr_t  id_rs,
    output cpu_cfg_pkg::reg_addr_t  id_rt,
    output cpu_cfg_pkg::reg_addr_t  id_rd,
    output cpu_cfg_pkg::word_t      id_a,
    output cpu_cfg_pkg::word_t      id_b,
    output cpu_cfg_pkg::word_t      id_imm,
    output cpu_isa_pkg::alu_op_t    id_alu_op,
    output logic                    id_alu_src, // Immediate replaces operand a
    output logic                    id_mem_rd,
    output logic                    id_mem_wr,
    output logic                    id_wr_reg
);
    import cpu_cfg_pkg::*;
    import cpu_isa_pkg::*;

    opcode_t                    op;
    reg_addr_t                  rd_field;
    logic [FUNCT_MSB:FUNCT_LSB] funct;
    logic [IMM_W-1:0]           imm;
    word_t                      imm_se;
    logic                       is_li;      // Load immediate into r0
    logic                       is_r;       // One of the kept R-format opcodes
    logic                       dec_mem_rd;
    logic                       dec_mem_wr;
    logic                       dec_wr_reg;
    alu_op_t                    dec_alu_op;

    // Field split
    assign op       = if_instr[OP_MSB:OP_LSB];
    assign rs_addr  = if_instr[RS_MSB:RS_LSB];
    assign rt_addr  = if_instr[RT_MSB:RT_LSB];
    assign rd_field = if_instr[RD_MSB:RD_LSB];
    assign funct    = if_instr[FUNCT_MSB:FUNCT_LSB];
    assign imm      = if_instr[IMM_MSB:IMM_LSB];
    assign imm_se   = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};

    // Top bits 01 is load immediate whatever the low op bits hold
    assign is_li = (op[5:4] == OP_LI[5:4]);
    assign is_r  = (op == OP_ALU) || (op == OP_ALU_WB) ||
                   (op == OP_STORE) || (op == OP_LOAD); // Anything else is a NOP

    // Control decode from the op bits
    assign dec_mem_rd = is_r & op[OP_MEM_BIT] & op[OP_WB_BIT];
    assign dec_mem_wr = is_r & op[OP_MEM_BIT] & ~op[OP_WB_BIT];
    assign dec_wr_reg = is_li | (is_r & op[OP_WB_BIT]); // Loads write rd as well
    assign dec_alu_op = is_li ? ALU_PASS : funct[FUNCT_MSB -: $bits(alu_op_t)];

    // ID/EX register
    always_ff @(posedge clk)
    begin
        id_a      <= rs_data;
        id_b      <= rt_data;
        id_imm    <= imm_se;
        id_alu_op <= dec_alu_op;
        if (rst)
        begin
            id_rs      <= '0;
            id_rt      <= '0;
            id_rd      <= '0;
            id_alu_src <= 1'b0;
            id_mem_rd  <= 1'b0;
            id_mem_wr  <= 1'b0;
            id_wr_reg  <= 1'b0;
        end
        else
        begin
            id_rs <= rs_addr;
            id_rt <= rt_addr;
            id_rd <= is_li ? reg_addr_t'(0) : rd_field; // Load immediate targets r0
            id_alu_src <= is_li & ~stall;
            id_mem_rd  <= dec_mem_rd & ~stall;           // Bubble on load-use
            id_mem_wr  <= dec_mem_wr & ~stall;
            id_wr_reg  <= dec_wr_reg & ~stall;
        end
    end

endmodule

// ==== reg_file.sv ====
/*
 * 32 x 32 register file with two combinational read ports and one write port.
 * A read of the register being written in the same cycle returns the new data.
 */
`timescale 1ns/1ps

module reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  cpu_cfg_pkg::reg_addr_t  rs_addr,
    input  cpu_cfg_pkg::reg_addr_t  rt_addr,
    input  cpu_cfg_pkg::reg_addr_t  wb_addr,
    input  cpu_cfg_pkg::word_t      wb_data,
    input  logic                    wb_wr,
    output cpu_cfg_pkg::word_t      rs_data,
    output cpu_cfg_pkg::word_t      rt_data
);
    import cpu_cfg_pkg::*;

    word_t regs [NUM_REGS];     // r0 is an ordinary register

    // Write-through read, WB result bypasses the array
    function automatic word_t read_port(input reg_addr_t addr);
        if (wb_wr && (wb_addr == addr))
            return wb_data;
        return regs[addr];
    endfunction

    always_comb
    begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_wr)
            regs[wb_addr] <= wb_data;
    end

    // Write-back data comes from the far end of the pipeline
    wb_known_chk: assert property (
        @(posedge clk) disable iff (rst) wb_wr |-> !$isunknown(wb_data)
    ) else $error("Register write with unknown data");

endmodule

// ==== hazard_unit.sv ====
/*
 * Load-use stall detection and EX operand forwarding selects.
 * Purely combinational, clock and reset feed only the checker.
 */
`timescale 1ns/1ps

module hazard_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  cpu_cfg_pkg::reg_addr_t  rs_addr,   // Instruction in decode
    input  cpu_cfg_pkg::reg_addr_t  rt_addr,
    input  cpu_cfg_pkg::reg_addr_t  id_rs,     // Instruction in execute
    input  cpu_cfg_pkg::reg_addr_t  id_rt,
    input  cpu_cfg_pkg::reg_addr_t  id_rd,
    input  logic                    id_mem_rd,
    input  cpu_cfg_pkg::reg_addr_t  ex_rd,     // EX/MEM destination
    input  logic                    ex_wr_reg,
    input  logic                    ex_mem_rd,
    input  cpu_cfg_pkg::reg_addr_t  wb_addr,   // MEM/WB destination
    input  logic                    wb_wr,
    output logic                    stall,
    output cpu_isa_pkg::fwd_sel_t   fwd_a,
    output cpu_isa_pkg::fwd_sel_t   fwd_b
);
    import cpu_cfg_pkg::*;
    import cpu_isa_pkg::*;

    // Newest producer wins, a load in EX/MEM has no data yet
    function automatic fwd_sel_t pick_src(input reg_addr_t src);
        if (ex_wr_reg && !ex_mem_rd && (ex_rd == src))
            return FWD_MEM;
        if (wb_wr && (wb_addr == src))
            return FWD_WB;
        return FWD_REG;
    endfunction

    always_comb
    begin
        fwd_a = pick_src(id_rs);
        fwd_b = pick_src(id_rt);
    end

    // Load in EX feeding the instruction in decode
    assign stall = id_mem_rd && ((id_rd == rs_addr) || (id_rd == rt_addr));

    // The bubble behind a load can never request another stall
    stall_once_chk: assert property (
        @(posedge clk) disable iff (rst) stall |=> !stall
    ) else $error("Stall held for two cycles");

endmodule

// ==== exec_pipeline.sv ====
/*
 * Execute, memory and write-back stages. Forwarding muxes and the ALU feed
 * EX/MEM, which drives the data port, and MEM/WB selects the register result.
 */
`timescale 1ns/1ps

module exec_pipeline (
    input  logic                    clk,
    input  logic                    rst,
    input  cpu_cfg_pkg::word_t      id_a,
    input  cpu_cfg_pkg::word_t      id_b,
    input  cpu_cfg_pkg::word_t      id_imm,
    input  cpu_cfg_pkg::reg_addr_t  id_rd,
    input  cpu_isa_pkg::alu_op_t    id_alu_op,
    input  logic                    id_alu_src,
    input  logic                    id_mem_rd,
    input  logic                    id_mem_wr,
    input  logic                    id_wr_reg,
    input  cpu_isa_pkg::fwd_sel_t   fwd_a,
    input  cpu_isa_pkg::fwd_sel_t   fwd_b,
    input  cpu_cfg_pkg::word_t      d_rdata,
    output cpu_cfg_pkg::word_t      d_addr,
    output cpu_cfg_pkg::word_t      d_wdata,
    output logic                    d_rd,
    output logic                    d_wr,
    output cpu_cfg_pkg::reg_addr_t  ex_rd,
    output logic                    ex_wr_reg,
    output logic                    ex_mem_rd,
    output cpu_cfg_pkg::reg_addr_t  wb_addr,
    output cpu_cfg_pkg::word_t      wb_data,
    output logic                    wb_wr
);
    import cpu_cfg_pkg::*;
    import cpu_isa_pkg::*;

    word_t opnd_a, opnd_b;      // Forwarded register operands
    word_t alu_a, alu_y;
    word_t ex_result;           // EX/MEM ALU result, also the data address
    word_t ex_store;            // EX/MEM store data from rt
    logic  ex_mem_wr;
    word_t wb_mem_data;         // MEM/WB payload
    word_t wb_alu;
    logic  wb_load;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val);
        case (sel)
            FWD_MEM: return ex_result;
            FWD_WB:  return wb_data;
            default: return reg_val;
        endcase
    endfunction

    always_comb
    begin
        opnd_a = fwd_mux(fwd_a, id_a);
        opnd_b = fwd_mux(fwd_b, id_b);
    end

    assign alu_a = id_alu_src ? id_imm : opnd_a; // Load immediate path

    alu u_alu (
        .a  (alu_a),
        .b  (opnd_b),
        .op (id_alu_op),
        .y  (alu_y)
    );

    // EX/MEM register
    always_ff @(posedge clk)
    begin
        ex_result <= alu_y;
        ex_store  <= opnd_b;
        ex_rd     <= id_rd;
        if (rst)
        begin
            ex_wr_reg <= 1'b0;
            ex_mem_rd <= 1'b0;
            ex_mem_wr <= 1'b0;
        end
        else
        begin
            ex_wr_reg <= id_wr_reg;
            ex_mem_rd <= id_mem_rd;
            ex_mem_wr <= id_mem_wr;
        end
    end

    // Data memory port
    assign d_addr  = ex_result;
    assign d_wdata = ex_store;
    assign d_rd    = ex_mem_rd;
    assign d_wr    = ex_mem_wr; // Memory commits on the closing edge

    // MEM/WB register
    always_ff @(posedge clk)
    begin
        wb_mem_data <= d_rdata;
        wb_alu      <= ex_result;
        wb_addr     <= ex_rd;
        if (rst)
        begin
            wb_load <= 1'b0;
            wb_wr   <= 1'b0;
        end
        else
        begin
            wb_load <= ex_mem_rd;
            wb_wr   <= ex_wr_reg;
        end
    end

    assign wb_data = wb_load ? wb_mem_data : wb_alu;

    // Decode never marks one instruction as both load and store
    mem_excl_chk: assert property (
        @(posedge clk) disable iff (rst) !(d_rd && d_wr)
    ) else $error("Data read and write in the same cycle");

endmodule

// ==== cpu_top.sv ====
/*
 * Top level of the five-stage load/store core.
 * Connects fetch, decode, register file, hazard unit and execute pipeline.
 */
`timescale 1ns/1ps

module cpu_top (
    input  logic                clk,
    input  logic                rst,
    input  cpu_isa_pkg::instr_t i_data,
    input  cpu_cfg_pkg::word_t  d_rdata,
    output cpu_cfg_pkg::word_t  i_addr,
    output cpu_cfg_pkg::word_t  d_addr,
    output cpu_cfg_pkg::word_t  d_wdata,
    output logic                d_rd,
    output logic                d_wr
);
    import cpu_cfg_pkg::*;
    import cpu_isa_pkg::*;

    instr_t    if_instr;
    reg_addr_t rs_addr, rt_addr;
    word_t     rs_data, rt_data;
    reg_addr_t id_rs, id_rt, id_rd;
    word_t     id_a, id_b, id_imm;
    alu_op_t   id_alu_op;
    logic      id_alu_src, id_mem_rd, id_mem_wr, id_wr_reg;
    reg_addr_t ex_rd;
    logic      ex_wr_reg, ex_mem_rd;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      wb_wr;
    logic      stall;
    fwd_sel_t  fwd_a, fwd_b;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst), .stall(stall), .i_data(i_data),
        .i_addr(i_addr), .if_instr(if_instr)
    );

    decode_unit u_decode (
        .clk(clk), .rst(rst), .stall(stall), .if_instr(if_instr),
        .rs_data(rs_data), .rt_data(rt_data), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .id_rs(id_rs), .id_rt(id_rt), .id_rd(id_rd),
        .id_a(id_a), .id_b(id_b), .id_imm(id_imm), .id_alu_op(id_alu_op),
        .id_alu_src(id_alu_src), .id_mem_rd(id_mem_rd), .id_mem_wr(id_mem_wr),
        .id_wr_reg(id_wr_reg)
    );

    reg_file u_regs (
        .clk(clk), .rst(rst), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .wb_addr(wb_addr), .wb_data(wb_data), .wb_wr(wb_wr),
        .rs_data(rs_data), .rt_data(rt_data)
    );

    hazard_unit u_hazard (
        .clk(clk), .rst(rst), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .id_rs(id_rs), .id_rt(id_rt), .id_rd(id_rd), .id_mem_rd(id_mem_rd),
        .ex_rd(ex_rd), .ex_wr_reg(ex_wr_reg), .ex_mem_rd(ex_mem_rd),
        .wb_addr(wb_addr), .wb_wr(wb_wr),
        .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    exec_pipeline u_exec (
        .clk(clk), .rst(rst), .id_a(id_a), .id_b(id_b), .id_imm(id_imm),
        .id_rd(id_rd), .id_alu_op(id_alu_op), .id_alu_src(id_alu_src),
        .id_mem_rd(id_mem_rd), .id_mem_wr(id_mem_wr), .id_wr_reg(id_wr_reg),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .d_rdata(d_rdata),
        .d_addr(d_addr), .d_wdata(d_wdata), .d_rd(d_rd), .d_wr(d_wr),
        .ex_rd(ex_rd), .ex_wr_reg(ex_wr_reg), .ex_mem_rd(ex_mem_rd),
        .wb_addr(wb_addr), .wb_data(wb_data), .wb_wr(wb_wr)
    );

endmodule

// ==== tb_cpu.sv ====
/*
 * Directed testbench for the five-stage core. Models both memories, builds
 * short programs and checks every store against a sequential ISA model.
 */
`timescale 1ns/1ps

module tb_cpu;
    import cpu_cfg_pkg::*;
    import cpu_isa_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int IMEM_WORDS   = 256;
    localparam int CYC_ALU      = 60;   // Cycles each test runs after reset
    localparam int CYC_CHAIN    = 60;
    localparam int CYC_LOAD     = 60;
    localparam int CYC_NOWB     = 50;
    localparam int CYC_RAND     = 160;
    localparam int TOTAL_CYCLES = CYC_ALU + CYC_CHAIN + CYC_LOAD + CYC_NOWB + CYC_RAND;

    logic   clk;
    logic   rst;
    instr_t i_data;
    word_t  d_rdata;
    word_t  i_addr;
    word_t  d_addr;
    word_t  d_wdata;
    logic   d_rd;
    logic   d_wr;

    instr_t imem [IMEM_WORDS];
    word_t  dmem [word_t];      // Sparse data memory seen by the DUT
    word_t  log_addr [$];       // Every store the DUT made
    word_t  log_data [$];
    int     rd_count;           // Cycles with d_rd high

    word_t  model_regs [NUM_REGS];
    word_t  model_mem [word_t];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    int     exp_loads;
    int     prog_len;

    int     err_count;
    int     pass_count;
    int     fail_count;
    int     seed_ret;

    cpu_top DUT (
        .clk(clk), .rst(rst), .i_data(i_data), .d_rdata(d_rdata),
        .i_addr(i_addr), .d_addr(d_addr), .d_wdata(d_wdata), .d_rd(d_rd), .d_wr(d_wr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Untouched locations read a pattern of the full address
    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic word_t read_dmem(input word_t addr);
        if (dmem.exists(addr))
            return dmem[addr];
        return fill_word(addr);
    endfunction

    function automatic word_t read_model_mem(input word_t addr);
        if (model_mem.exists(addr))
            return model_mem[addr];
        return fill_word(addr);
    endfunction

    // Both memories answer half a cycle after the address settles
    always @(negedge clk)
    begin
        if (d_wr === 1'b1)
        begin
            dmem[d_addr] = d_wdata;
            log_addr.push_back(d_addr);
            log_data.push_back(d_wdata);
        end
        if (d_rd === 1'b1)
        begin
            rd_count = rd_count + 1;
            d_rdata = read_dmem(d_addr);
        end
        else
            d_rdata = '0;
        if (i_addr < IMEM_WORDS * 4)
            i_data = imem[i_addr[9:2]];
        else
            i_data = NOP_INSTR;             // Past the program
    end

    function automatic instr_t li_word(input logic [IMM_W-1:0] imm);
        return {OP_LI, imm};
    endfunction

    function automatic instr_t r_word(input opcode_t op, input reg_addr_t rs,
                                      input reg_addr_t rt, input reg_addr_t rd,
                                      input alu_op_t aop);
        return {op, rs, rt, rd, 5'b0, aop, 3'b0}; // funct low bits unused
    endfunction

    function automatic word_t expect_alu(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            default: return '0;
        endcase
    endfunction

    // One held fetch cycle per load whose next word names its rd as rs or rt
    function automatic int count_stalls();
        int     n;
        instr_t cur;
        instr_t nxt;
        n = 0;
        for (int k = 0; k < prog_len; k++)
        begin
            cur = imem[8'(k)];
            nxt = imem[8'(k + 1)];          // NOP fill after the last word
            if ((cur[OP_MSB:OP_LSB] == OP_LOAD) &&
                ((nxt[RS_MSB:RS_LSB] == cur[RD_MSB:RD_LSB]) ||
                 (nxt[RT_MSB:RT_LSB] == cur[RD_MSB:RD_LSB])))
                n++;
        end
        return n;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic new_program;
        for (int k = 0; k < IMEM_WORDS; k++)
            imem[8'(k)] = NOP_INSTR;
        for (int k = 0; k < NUM_REGS; k++)
            model_regs[5'(k)] = '0;         // Matches the register reset
        model_mem.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_loads = 0;
        prog_len  = 0;
    endtask

    task automatic insert_word(input instr_t w);
        imem[8'(prog_len)] = w;
        prog_len++;
    endtask

    task automatic li_to_r0(input logic [IMM_W-1:0] imm);
        insert_word(li_word(imm));
        model_regs[0] = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
    endtask

    task automatic do_alu(input logic wb, input alu_op_t op, input reg_addr_t rd,
                          input reg_addr_t rs, input reg_addr_t rt);
        insert_word(r_word(wb ? OP_ALU_WB : OP_ALU, rs, rt, rd, op));
        if (wb)
            model_regs[rd] = expect_alu(op, model_regs[rs], model_regs[rt]);
    endtask

    // Load immediate then copy r0 out with OR
    task automatic set_reg(input reg_addr_t rd, input logic [IMM_W-1:0] imm);
        li_to_r0(imm);
        do_alu(1'b1, ALU_OR, rd, 5'd0, 5'd0);
    endtask

    task automatic store_reg(input reg_addr_t rs, input reg_addr_t rt);
        word_t addr;
        addr = model_regs[rs] + model_regs[rt];
        insert_word(r_word(OP_STORE, rs, rt, 5'd0, ALU_ADD));
        model_mem[addr] = model_regs[rt];
        exp_addr.push_back(addr);
        exp_data.push_back(model_regs[rt]);
    endtask

    task automatic load_reg(input reg_addr_t rd, input reg_addr_t rs, input reg_addr_t rt);
        word_t addr;
        addr = model_regs[rs] + model_regs[rt];
        insert_word(r_word(OP_LOAD, rs, rt, rd, ALU_ADD));
        model_regs[rd] = read_model_mem(addr);
        exp_loads++;
    endtask

    task automatic apply_reset;
        @(negedge clk);
        rst = 1'b1;
        dmem.delete();
        log_addr.delete();
        log_data.delete();
        rd_count = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_and_check(input string name, input int cycles);
        int errs_before;
        errs_before = err_count;
        apply_reset();
        repeat (cycles) @(negedge clk);   // Program plus pipeline drain
        // PC steps once per cycle except while a load-use stall holds it
        check_value("i_addr", PC_STEP * (cycles - count_stalls()), i_addr);
        check_value("store_count", exp_addr.size(), log_addr.size());
        for (int k = 0; k < exp_addr.size() && k < log_addr.size(); k++)
        begin
            check_value($sformatf("d_addr[%0d]", k), exp_addr[k], log_addr[k]);
            check_value($sformatf("d_wdata[%0d]", k), exp_data[k], log_data[k]);
        end
        check_value("d_rd_count", exp_loads, rd_count);
        if (err_count == errs_before)
        begin
            pass_count++;
            $display("Test %s passed", name);
        end
        else
        begin
            fail_count++;
            $display("Test %s failed, %0d mismatches", name, err_count - errs_before);
        end
    endtask

    task automatic all_alu_ops;
        new_program();
        set_reg(5'd30, 26'h000_0100);             // Store base
        set_reg(5'd1, 26'h012_3456);
        set_reg(5'd2, 26'h3FF_FF00);              // Negative, sign-extends
        for (int k = 0; k < 5; k++)
            do_alu(1'b1, alu_op_t'(k), reg_addr_t'(3 + k), 5'd1, 5'd2);
        do_alu(1'b1, ALU_SUB, 5'd8, 5'd2, 5'd1);  // Swapped operands
        for (int k = 0; k < 6; k++)
            store_reg(5'd30, reg_addr_t'(3 + k));
        store_reg(5'd30, 5'd0);                   // Last immediate still in r0
        run_and_check("all_alu_ops", CYC_ALU);
    endtask

    task automatic forward_chain;
        new_program();
        set_reg(5'd30, 26'h000_0200);
        set_reg(5'd1, 26'h000_0005);
        set_reg(5'd2, 26'h000_002C);
        do_alu(1'b1, ALU_ADD, 5'd3, 5'd2, 5'd1);
        do_alu(1'b1, ALU_SUB, 5'd4, 5'd3, 5'd2);  // One back from EX/MEM, two back from WB
        do_alu(1'b1, ALU_XOR, 5'd5, 5'd4, 5'd3);
        do_alu(1'b1, ALU_OR,  5'd6, 5'd5, 5'd4);
        do_alu(1'b1, ALU_AND, 5'd7, 5'd6, 5'd5);
        store_reg(5'd30, 5'd7);                   // Store data forwarded
        do_alu(1'b1, ALU_ADD, 5'd8, 5'd7, 5'd6);
        store_reg(5'd8, 5'd7);                    // Address operand forwarded
        for (int k = 3; k < 7; k++)
            store_reg(5'd30, reg_addr_t'(k));
        run_and_check("forward_chain", CYC_CHAIN);
    endtask

    task automatic load_use_stall;
        new_program();
        set_reg(5'd30, 26'h000_0040);
        set_reg(5'd6, 26'h000_0123);
        store_reg(5'd30, 5'd6);
        load_reg(5'd5, 5'd30, 5'd6);              // Reads back the store
        do_alu(1'b1, ALU_ADD, 5'd7, 5'd5, 5'd6);  // Stall on rs
        store_reg(5'd30, 5'd7);
        load_reg(5'd8, 5'd30, 5'd30);             // Fill pattern
        store_reg(5'd30, 5'd8);                   // Stall on store data
        load_reg(5'd9, 5'd8, 5'd30);
        do_alu(1'b1, ALU_XOR, 5'd10, 5'd9, 5'd8);
        store_reg(5'd30, 5'd10);
        run_and_check("load_use_stall", CYC_LOAD);
    endtask

    task automatic dropped_writes;
        new_program();
        set_reg(5'd30, 26'h000_0300);
        set_reg(5'd9, 26'h2AB_CDEF);
        do_alu(1'b0, ALU_XOR, 5'd9, 5'd9, 5'd9);                      // Result dropped
        insert_word(r_word(6'b111100, 5'd9, 5'd9, 5'd9, ALU_ADD));   // Top bits 11
        insert_word(r_word(6'b101100, 5'd30, 5'd9, 5'd9, ALU_ADD));  // Load-like, top 10
        insert_word(r_word(6'b111000, 5'd30, 5'd9, 5'd0, ALU_ADD));  // Store-like NOP
        store_reg(5'd30, 5'd9);
        run_and_check("dropped_writes", CYC_NOWB);
    endtask

    task automatic random_ops;
        logic [IMM_W-1:0] a_imm;
        logic [IMM_W-1:0] b_imm;
        alu_op_t          op;
        new_program();
        set_reg(5'd30, 26'h000_0400);
        for (int k = 0; k < 20; k++)
        begin
            a_imm = IMM_W'($urandom);
            b_imm = IMM_W'($urandom);
            op    = alu_op_t'($urandom_range(4, 0));
            li_to_r0(a_imm);
            do_alu(1'b1, ALU_OR, 5'd1, 5'd0, 5'd0);
            li_to_r0(b_imm);
            do_alu(1'b1, ALU_ADD, 5'd2, 5'd0, 5'd1);  // Mixed for full-width values
            do_alu(1'b1, op, 5'd3, 5'd1, 5'd2);
            store_reg(5'd30, 5'd3);
        end
        run_and_check("random_ops", CYC_RAND);
    endtask

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        i_data     = NOP_INSTR;
        d_rdata    = '0;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        rd_count   = 0;
        seed_ret   = $urandom(97463);
        all_alu_ops();
        forward_chain();
        load_use_stall();
        dropped_writes();
        random_ops();
        $display("Tests finished: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Twice the planned run time
    initial
    begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Simulation timed out after %0d cycles", 2 * TOTAL_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
cpu_cfg_pkg.sv
cpu_isa_pkg.sv
alu.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
hazard_unit.sv
exec_pipeline.sv
cpu_top.sv
tb_cpu.sv

// ==== Makefile ====
# Verilator build of the core testbench
SRCS := $(shell cat project.f)

obj_dir/Vtb_cpu: project.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_cpu -f project.f

.PHONY: run clean

run: obj_dir/Vtb_cpu
	@out="$$(./obj_dir/Vtb_cpu)"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
